/* logic/conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// tile geometry, lane index is row * CONV_PARA_Y + column
`define CONV_PARA_X 2
`define CONV_PARA_Y 2

`define CONV_DATA_WIDTH 16 // float16 words

// kernel size range and the beat counter that covers K*K
`define CONV_KERNEL_MAX 5
`define CONV_KSIZE_WIDTH 3
`define CONV_COUNT_WIDTH 5

// register map of the AXI4-Lite slave
`define CONV_REG_KSIZE 4'h0
`define CONV_REG_DONE_CNT 4'h4

`endif

/* logic/fp16_pkg.sv */
`include "conv_cfg.svh"

package fp16_pkg;

	localparam int LANES = `CONV_PARA_X * `CONV_PARA_Y;
	localparam int MANT_W = `CONV_DATA_WIDTH - 6; // sign and 5-bit exponent take the rest

	typedef struct packed {
		logic              sign;
		logic [4:0]        exp;  // bias 15, zero means zero
		logic [MANT_W-1:0] mant;
	} fp16_t;

	// lane i sits at row i / CONV_PARA_Y, column i % CONV_PARA_Y
	typedef fp16_t [LANES-1:0] pixel_tile_t;

	// one accepted beat of the data path
	typedef struct packed {
		logic        valid;
		pixel_tile_t tile;
		fp16_t       weight; // shared by every lane
	} conv_beat_t;

	typedef struct packed {
		logic        valid; // one cycle per finished window
		pixel_tile_t tile;
	} conv_result_t;

endpackage

/* logic/axil_pkg.sv */
package axil_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	typedef enum logic [1:0] {
		AXIL_OKAY   = 2'b00,
		AXIL_SLVERR = 2'b10
	} axil_resp_e;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
	} axil_w_t;

	typedef struct packed {
		logic       valid;
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
		axil_resp_e        resp;
	} axil_r_t;

endpackage

/* logic/fp16_mult_add.sv */
`timescale 1ns/1ps

module fp16_mult_add (
	input  logic            clk,
	input  logic            rst,
	input  logic            beat_valid,
	input  logic            first,
	input  fp16_pkg::fp16_t a,
	input  fp16_pkg::fp16_t b,
	input  logic            last,
	output logic            sum_valid,
	output fp16_pkg::fp16_t sum
);
	import fp16_pkg::*;

	logic [21:0]       sig_prod;
	logic signed [7:0] prod_exp;
	fp16_t             prod_next;
	fp16_t             prod_q;     // stage 1 product
	logic              prod_valid;
	logic              prod_first;
	logic              prod_last;
	fp16_t             acc;
	fp16_t             hi_op;
	fp16_t             lo_op;
	logic [13:0]       hi_ext;     // hidden bit, 10 mantissa bits, guard/round/sticky
	logic [13:0]       lo_ext;
	logic [13:0]       lo_sh;
	logic [4:0]        exp_diff;
	logic              sticky;
	logic [14:0]       raw;
	logic [14:0]       norm;
	logic [3:0]        lead;
	logic [3:0]        lshift;
	logic signed [6:0] sum_exp;
	fp16_t             add_out;

	// stage 1 multiply, truncated
	always_comb begin
		sig_prod = {1'b1, a.mant} * {1'b1, b.mant};
		prod_exp = $signed({3'b000, a.exp}) + $signed({3'b000, b.exp})
			+ $signed({7'd0, sig_prod[21]}) - 8'sd15;
		prod_next.sign = a.sign ^ b.sign;
		prod_next.exp  = prod_exp[4:0];
		prod_next.mant = sig_prod[21] ? sig_prod[20:11] : sig_prod[19:10];
		if (a.exp == 5'd0 || b.exp == 5'd0 || prod_exp <= 8'sd0) begin
			prod_next.exp  = '0; // zero, subnormal or underflow
			prod_next.mant = '0;
		end else if (prod_exp >= 8'sd31) begin
			prod_next.exp  = 5'd30; // largest finite, as truncation would give
			prod_next.mant = '1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= beat_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid) begin
			prod_q     <= prod_next;
			prod_first <= first;
			prod_last  <= last;
		end
	end

	// stage 2 aligned add of product and accumulator
	always_comb begin
		hi_op    = ({acc.exp, acc.mant} >= {prod_q.exp, prod_q.mant}) ? acc : prod_q;
		lo_op    = ({acc.exp, acc.mant} >= {prod_q.exp, prod_q.mant}) ? prod_q : acc;
		hi_ext   = (hi_op.exp == 5'd0) ? '0 : {1'b1, hi_op.mant, 3'b000};
		lo_ext   = (lo_op.exp == 5'd0) ? '0 : {1'b1, lo_op.mant, 3'b000};
		exp_diff = hi_op.exp - lo_op.exp;
		lo_sh    = lo_ext >> exp_diff;
		sticky   = |(lo_ext & ~(14'h3fff << exp_diff)); // bits shifted out
		if (hi_op.sign == lo_op.sign) begin
			raw = {1'b0, hi_ext} + {1'b0, lo_sh};
		end else begin
			raw = {1'b0, hi_ext} - {1'b0, lo_sh[13:1], lo_sh[0] | sticky};
		end

		lead = 4'd0;
		for (int i = 0; i < 15; i++) begin
			if (raw[i]) begin
				lead = 4'(i);
			end
		end
		lshift = 4'd13 - lead;
		if (raw[14]) begin // carry out of the add
			norm    = raw >> 1;
			sum_exp = $signed({2'b00, hi_op.exp}) + 7'sd1;
		end else begin
			norm    = raw << lshift;
			sum_exp = $signed({2'b00, hi_op.exp}) - $signed({3'b000, lshift});
		end

		add_out.sign = hi_op.sign;
		add_out.exp  = sum_exp[4:0];
		add_out.mant = norm[12:3];
		if (raw == '0) begin
			add_out      = '0;
			add_out.sign = hi_op.sign & lo_op.sign; // cancellation gives +0
		end else if (sum_exp <= 7'sd0) begin
			add_out.exp  = '0;
			add_out.mant = '0;
		end else if (sum_exp >= 7'sd31) begin
			add_out.exp  = 5'd30;
			add_out.mant = '1;
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			acc <= prod_first ? prod_q : add_out; // first beat starts a fresh window
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= prod_valid & prod_last;
		end
	end

	assign sum = acc;

endmodule

/* logic/conv_para_scale.sv */
`timescale 1ns/1ps

`include "conv_cfg.svh"

module conv_para_scale (
	input  logic                         clk,
	input  logic                         rst,
	input  fp16_pkg::conv_beat_t         beat,
	input  logic [`CONV_KSIZE_WIDTH-1:0] ksize,
	output fp16_pkg::conv_result_t       result,
	output logic                         window_done
);
	import fp16_pkg::*;

	logic [`CONV_COUNT_WIDTH-1:0]   beat_cnt;  // beats taken in the open window
	logic [`CONV_COUNT_WIDTH-1:0]   win_len;   // K*K latched at the first beat
	logic [2*`CONV_KSIZE_WIDTH-1:0] ksize_sq;
	logic [`CONV_COUNT_WIDTH-1:0]   cur_len;
	logic                           first;
	logic                           last;
	logic [LANES-1:0]               lane_valid;
	pixel_tile_t                    lane_sum;
	logic                           res_valid;
	pixel_tile_t                    res_tile;

	assign ksize_sq = ksize * ksize;

	// the first beat uses the live register, later beats the latched length
	assign first   = beat.valid && (beat_cnt == '0);
	assign cur_len = (beat_cnt == '0) ? ksize_sq[`CONV_COUNT_WIDTH-1:0] : win_len;
	assign last    = beat.valid && (beat_cnt + 1'b1 == cur_len);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_cnt <= '0;
			win_len  <= '0;
		end else if (beat.valid) begin
			if (first) begin
				win_len <= cur_len;
			end
			beat_cnt <= last ? '0 : beat_cnt + 1'b1; // next beat may open a new window
		end
	end

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		fp16_mult_add u_lane (
			.clk        (clk),
			.rst        (rst),
			.beat_valid (beat.valid),
			.first      (first),
			.a          (beat.tile[i]),
			.b          (beat.weight),
			.last       (last),
			.sum_valid  (lane_valid[i]),
			.sum        (lane_sum[i])
		);
	end

	// all lanes finish together, two cycles after the closing beat
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= &lane_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (&lane_valid) begin
			res_tile <= lane_sum; // held until the next window closes
		end
	end

	assign result.valid = res_valid;
	assign result.tile  = res_tile;
	assign window_done  = res_valid;

endmodule

/* logic/conv_csr_axil.sv */
`timescale 1ns/1ps

`include "conv_cfg.svh"

module conv_csr_axil (
	input  logic                         clk,
	input  logic                         rst,
	input  axil_pkg::axil_aw_t           aw,
	output logic                         awready,
	input  axil_pkg::axil_w_t            w,
	output logic                         wready,
	output axil_pkg::axil_b_t            b,
	input  logic                         bready,
	input  axil_pkg::axil_ar_t           ar,
	output logic                         arready,
	output axil_pkg::axil_r_t            r,
	input  logic                         rready,
	input  logic                         window_done,
	output logic [`CONV_KSIZE_WIDTH-1:0] ksize
);
	import axil_pkg::*;

	localparam logic [`CONV_KSIZE_WIDTH-1:0] KSIZE_RST = 3;

	logic              bvalid_q;
	axil_resp_e        bresp_q;
	logic              rvalid_q;
	logic [DATA_W-1:0] rdata_q;
	axil_resp_e        rresp_q;
	logic [DATA_W-1:0] done_cnt; // completed windows, wraps
	logic              wr_ok;
	logic [DATA_W-1:0] rdata_d;
	axil_resp_e        rresp_d;

	// only the kernel-size register is writable, and only within 1..K max
	assign wr_ok = (aw.addr == `CONV_REG_KSIZE) && (w.data != '0)
		&& (w.data <= `CONV_KERNEL_MAX);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid_q <= 1'b0;
			ksize    <= KSIZE_RST;
		end else begin
			awready <= aw.valid && w.valid && !awready && !bvalid_q;
			wready  <= aw.valid && w.valid && !awready && !bvalid_q;
			if (awready) begin // aw and w both transfer this cycle
				bvalid_q <= 1'b1;
				if (wr_ok) begin
					ksize <= w.data[`CONV_KSIZE_WIDTH-1:0];
				end
			end else if (bvalid_q && bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (awready) begin
			bresp_q <= wr_ok ? AXIL_OKAY : AXIL_SLVERR;
		end
	end

	always_comb begin
		rdata_d = '0;
		rresp_d = AXIL_OKAY;
		case (ar.addr)
			`CONV_REG_KSIZE:    rdata_d = {{(DATA_W-`CONV_KSIZE_WIDTH){1'b0}}, ksize};
			`CONV_REG_DONE_CNT: rdata_d = done_cnt;
			default:            rresp_d = AXIL_SLVERR;
		endcase
	end

	assign arready = !rvalid_q; // one read outstanding at most

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rvalid_q <= 1'b0;
			done_cnt <= '0;
		end else begin
			if (ar.valid && arready) begin
				rvalid_q <= 1'b1;
			end else if (rready) begin
				rvalid_q <= 1'b0;
			end
			if (window_done) begin
				done_cnt <= done_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar.valid && arready) begin
			rdata_q <= rdata_d;
			rresp_q <= rresp_d;
		end
	end

	assign b.valid = bvalid_q;
	assign b.resp  = bresp_q;
	assign r.valid = rvalid_q;
	assign r.data  = rdata_q;
	assign r.resp  = rresp_q;

endmodule

/* logic/conv_core_top.sv */
`timescale 1ns/1ps

`include "conv_cfg.svh"

module conv_core_top (
	input  logic                   clk,
	input  logic                   rst,
	input  fp16_pkg::conv_beat_t   beat,
	output fp16_pkg::conv_result_t result,
	input  axil_pkg::axil_aw_t     aw,
	output logic                   awready,
	input  axil_pkg::axil_w_t      w,
	output logic                   wready,
	output axil_pkg::axil_b_t      b,
	input  logic                   bready,
	input  axil_pkg::axil_ar_t     ar,
	output logic                   arready,
	output axil_pkg::axil_r_t      r,
	input  logic                   rready
);

	logic [`CONV_KSIZE_WIDTH-1:0] ksize;       // sampled at each window start
	logic                         window_done;

	// configuration side
	conv_csr_axil u_csr (
		.clk         (clk),
		.rst         (rst),
		.aw          (aw),
		.awready     (awready),
		.w           (w),
		.wready      (wready),
		.b           (b),
		.bready      (bready),
		.ar          (ar),
		.arready     (arready),
		.r           (r),
		.rready      (rready),
		.window_done (window_done),
		.ksize       (ksize)
	);

	conv_para_scale u_scale (
		.clk         (clk),
		.rst         (rst),
		.beat        (beat),
		.ksize       (ksize),
		.result      (result),
		.window_done (window_done)
	);

endmodule

/* tb/conv_core_assert.sv */
`timescale 1ns/1ps

`include "conv_cfg.svh"

module conv_core_assert (
	input logic                         clk,
	input logic                         rst,
	input fp16_pkg::conv_beat_t         beat,
	input fp16_pkg::conv_result_t       result,
	input logic [`CONV_KSIZE_WIDTH-1:0] ksize,
	input axil_pkg::axil_b_t            b,
	input logic                         bready,
	input axil_pkg::axil_r_t            r,
	input logic                         rready
);

	int unsigned fail_count = 0;
	int unsigned beats_in;   // beats of the open window
	int unsigned window_len; // K*K taken at the window's first beat
	logic        closing_beat;

	assign closing_beat = beat.valid
		&& (beats_in + 1 == ((beats_in == 0) ? ksize * ksize : window_len));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beats_in   <= 0;
			window_len <= 0;
		end else if (beat.valid) begin
			if (beats_in == 0) begin
				window_len <= ksize * ksize;
			end
			beats_in <= closing_beat ? 0 : beats_in + 1;
		end
	end

	b_hold: assert property (@(posedge clk) disable iff (!rst) b.valid && !bready |=> b.valid)
		else begin
			$error("write response dropped before bready");
			fail_count++;
		end

	r_hold: assert property (@(posedge clk) disable iff (!rst) r.valid && !rready |=> r.valid)
		else begin
			$error("read response dropped before rready");
			fail_count++;
		end

	// one cycle per window even back to back
	result_pulse: assert property (@(posedge clk) disable iff (!rst)
		result.valid |=> !result.valid)
		else begin
			$error("result valid lasted two cycles");
			fail_count++;
		end

	// valid rises at the second edge after the closing beat and is sampled at the third
	result_after_close: assert property (@(posedge clk) disable iff (!rst)
		closing_beat |-> ##3 result.valid)
		else begin
			$error("result valid missing two cycles after the closing beat");
			fail_count++;
		end

	result_has_close: assert property (@(posedge clk) disable iff (!rst)
		result.valid |-> $past(closing_beat, 3))
		else begin
			$error("result valid without a closing beat two cycles earlier");
			fail_count++;
		end

endmodule

bind conv_core_top conv_core_assert u_assert (
	.clk    (clk),
	.rst    (rst),
	.beat   (beat),
	.result (result),
	.ksize  (ksize),
	.b      (b),
	.bready (bready),
	.r      (r),
	.rready (rready)
);

/* tb/tb_conv_core.sv */
`timescale 1ns/1ps

`include "conv_cfg.svh"

module tb_conv_core;
	import fp16_pkg::*;
	import axil_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int MODE_RANDOM = 0;
	localparam int MODE_ONES   = 1;
	localparam int MODE_CANCEL = 2; // odd beats repeat the tile with the weight negated
	// data beats of all tests including gaps, then cycles for register traffic and reset
	localparam int TEST_BEATS  = 9 + 3 * 4 + 4 + 2 * 25 + 4 * 5 + 2 * 9;
	localparam int AXI_SLACK   = 12 * 20 + 10;
	localparam int WATCHDOG_CYCLES = (TEST_BEATS + AXI_SLACK) * 4;

	logic         clk;
	logic         rst;
	conv_beat_t   beat;
	conv_result_t result;
	axil_aw_t     aw;
	logic         awready;
	axil_w_t      w;
	logic         wready;
	axil_b_t      b;
	logic         bready;
	axil_ar_t     ar;
	logic         arready;
	axil_r_t      r;
	logic         rready;

	pixel_tile_t exp_q[$]; // expected tiles in window order
	pixel_tile_t exp_tile;
	string       test_name;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;
	int          windows_sent;
	axil_resp_e  resp;
	logic [31:0] rdata;

	conv_core_top u_conv_core_top (
		.clk     (clk),
		.rst     (rst),
		.beat    (beat),
		.result  (result),
		.aw      (aw),
		.awready (awready),
		.w       (w),
		.wready  (wready),
		.b       (b),
		.bready  (bready),
		.ar      (ar),
		.arready (arready),
		.r       (r),
		.rready  (rready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int rand_small();
		return int'($urandom_range(16)) - 8; // -8..8
	endfunction

	// exact for magnitudes below 2048
	function automatic fp16_t int_to_half(input int v);
		fp16_t h;
		int    m;
		int    p;
		h = '0;
		if (v != 0) begin
			h.sign = (v < 0);
			m = (v < 0) ? -v : v;
			p = 0;
			for (int i = 0; i < 12; i++) begin
				if ((m >> i) != 0) begin
					p = i;
				end
			end
			h.exp  = 5'(15 + p);
			h.mant = 10'((m << (10 - p)) & 'h3ff); // drop the hidden bit
		end
		return h;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] exp,
			input logic [31:0] got);
		assert (got === exp) else begin
			$display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", test_name, what,
				exp, got);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: pass", test_name);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d errors", test_name, test_errors);
		end
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data, input int stall,
			output axil_resp_e wresp);
		@(negedge clk);
		aw.valid = 1'b1;
		aw.addr  = addr;
		w.valid  = 1'b1;
		w.data   = data;
		do begin
			@(negedge clk);
		end while (!awready); // address and data transfer on the next edge
		check_equal("wready", 1, wready);
		@(negedge clk);
		aw.valid = 1'b0;
		w.valid  = 1'b0;
		while (!b.valid) begin
			@(negedge clk);
		end
		repeat (stall) @(negedge clk);
		wresp  = b.resp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, input int stall, output logic [31:0] data,
			output axil_resp_e rresp);
		@(negedge clk);
		ar.valid = 1'b1;
		ar.addr  = addr;
		do begin
			@(negedge clk);
		end while (!r.valid);
		ar.valid = 1'b0;
		check_equal("arready", 0, arready); // no new address while a read is pending
		repeat (stall) @(negedge clk); // response must hold meanwhile
		data   = r.data;
		rresp  = r.resp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// drives k*k beats and queues the tile the integer model expects
	task automatic send_window(input int k, input int gap_every, input int mode);
		int          sum [LANES];
		bit          neg_zero [LANES]; // every product so far was -0
		int          px [LANES];
		int          prev_px [LANES];
		int          wt;
		int          prev_wt;
		pixel_tile_t tile;
		for (int l = 0; l < LANES; l++) begin
			sum[l]      = 0;
			neg_zero[l] = 1'b1;
		end
		prev_wt = 0;
		for (int i = 0; i < k * k; i++) begin
			if (mode == MODE_ONES) begin
				wt = 1;
				foreach (px[l]) px[l] = 1;
			end else if (mode == MODE_CANCEL && i % 2 == 1) begin
				wt = -prev_wt;
				px = prev_px;
			end else begin
				wt = rand_small();
				foreach (px[l]) px[l] = rand_small();
			end
			prev_wt = wt;
			prev_px = px;
			@(negedge clk);
			beat.valid  = 1'b1;
			beat.weight = int_to_half(wt);
			for (int l = 0; l < LANES; l++) begin
				beat.tile[l] = int_to_half(px[l]);
				sum[l] += px[l] * wt;
				neg_zero[l] &= (px[l] * wt == 0) && ((px[l] < 0) != (wt < 0));
			end
			if (gap_every > 0 && i % gap_every == gap_every - 1 && i != k * k - 1) begin
				@(negedge clk);
				beat.valid = 1'b0; // idle cycle inside the window
			end
		end
		for (int l = 0; l < LANES; l++) begin
			tile[l] = (sum[l] == 0 && neg_zero[l]) ? 16'h8000 : int_to_half(sum[l]);
		end
		exp_q.push_back(tile);
		windows_sent++;
	endtask

	task automatic end_beats();
		@(negedge clk);
		beat.valid = 1'b0;
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%s: %0d results did not arrive in time", test_name, exp_q.size());
			test_errors++;
			exp_q.delete();
		end
	endtask

	// compares every lane of each result against the oldest expected tile
	always @(negedge clk) begin
		if (rst && result.valid) begin
			assert (exp_q.size() != 0) else begin
				$display("%s: result arrived with no window outstanding", test_name);
				test_errors++;
			end
			if (exp_q.size() != 0) begin
				exp_tile = exp_q.pop_front();
				for (int i = 0; i < LANES; i++) begin
					check_equal($sformatf("lane %0d", i), exp_tile[i], result.tile[i]);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run took too long and was stopped");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(88580));
		clk    = 1'b0;
		rst    = 1'b0;
		beat   = '0;
		aw     = '0;
		w      = '0;
		ar     = '0;
		bready = 1'b0;
		rready = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		start_test("reset_state");
		check_equal("result valid", 0, result.valid);
		check_equal("bvalid", 0, b.valid);
		check_equal("rvalid", 0, r.valid);
		check_equal("awready", 0, awready);
		check_equal("wready", 0, wready);
		check_equal("arready", 1, arready);
		axil_read(`CONV_REG_KSIZE, 0, rdata, resp);
		check_equal("ksize", 3, rdata);
		check_equal("ksize rresp", AXIL_OKAY, resp);
		axil_read(`CONV_REG_DONE_CNT, 0, rdata, resp);
		check_equal("done count", 0, rdata);
		finish_test();

		start_test("ones_k3");
		send_window(3, 0, MODE_ONES);
		end_beats();
		wait_results();
		finish_test();

		start_test("random_k2_k5");
		axil_write(`CONV_REG_KSIZE, 2, 0, resp);
		check_equal("bresp", AXIL_OKAY, resp);
		repeat (3) begin
			send_window(2, 0, MODE_RANDOM);
			end_beats();
		end
		send_window(2, 0, MODE_CANCEL); // exact zeros in every lane
		end_beats();
		wait_results();
		axil_write(`CONV_REG_KSIZE, 5, 0, resp);
		check_equal("bresp", AXIL_OKAY, resp);
		repeat (2) begin
			send_window(5, 0, MODE_RANDOM);
			end_beats();
		end
		wait_results();
		finish_test();

		start_test("back_to_back");
		axil_write(`CONV_REG_KSIZE, 2, 0, resp);
		repeat (3) send_window(2, 2, MODE_RANDOM);
		send_window(2, 2, MODE_CANCEL);
		end_beats();
		wait_results();
		finish_test();

		start_test("bad_writes");
		axil_write(`CONV_REG_KSIZE, 0, 0, resp);
		check_equal("bresp ksize 0", AXIL_SLVERR, resp);
		axil_write(`CONV_REG_KSIZE, 7, 0, resp);
		check_equal("bresp ksize 7", AXIL_SLVERR, resp);
		axil_read(`CONV_REG_KSIZE, 0, rdata, resp);
		check_equal("ksize kept", 2, rdata);
		axil_write(`CONV_REG_DONE_CNT, 1, 0, resp);
		check_equal("bresp counter", AXIL_SLVERR, resp);
		finish_test();

		start_test("done_count");
		axil_read(`CONV_REG_DONE_CNT, 5, rdata, resp);
		check_equal("done count", windows_sent, rdata);
		axil_write(`CONV_REG_KSIZE, 3, 4, resp);
		check_equal("bresp", AXIL_OKAY, resp);
		repeat (2) send_window(3, 0, MODE_RANDOM);
		end_beats();
		wait_results();
		axil_read(`CONV_REG_DONE_CNT, 3, rdata, resp);
		check_equal("done count", windows_sent, rdata);
		finish_test();

		$display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
			tests_passed, tests_failed, u_conv_core_top.u_assert.fail_count);
		if (tests_failed == 0 && u_conv_core_top.u_assert.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+logic
logic/fp16_pkg.sv
logic/axil_pkg.sv
logic/fp16_mult_add.sv
logic/conv_para_scale.sv
logic/conv_csr_axil.sv
logic/conv_core_top.sv
tb/conv_core_assert.sv
tb/tb_conv_core.sv

/* Bender.yml */
package:
  name: conv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/fp16_pkg.sv
      - logic/axil_pkg.sv
      - logic/fp16_mult_add.sv
      - logic/conv_para_scale.sv
      - logic/conv_csr_axil.sv
      - logic/conv_core_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/conv_core_assert.sv
      - tb/tb_conv_core.sv
